// ==== source/pci_tgt_pkg.sv ====
package pci_tgt_pkg;

    // bus commands the target answers, everything else is ignored
    typedef enum logic [3:0] {
        CMD_MEM_READ  = 4'b0110,
        CMD_MEM_WRITE = 4'b0111,
        CMD_CFG_READ  = 4'b1010,
        CMD_CFG_WRITE = 4'b1011
    } pci_cmd_e;

    // c/be# is a command in the address phase, byte enables after it
    typedef union packed {
        pci_cmd_e   cmd;
        logic [3:0] be_n;
    } pci_cbe_u;

    // decoder result for one address phase
    typedef struct packed {
        logic       hit;
        logic       is_cfg;
        logic       is_write;
        logic [7:0] idx;
    } pci_addr_s;

    // one completed data phase, for parity
    typedef struct packed {
        logic        valid;
        logic        is_write;
        logic [31:0] ad;
        logic [3:0]  cbe;
    } pci_data_s;

    // configuration header word indices
    localparam logic [7:0] CFG_ID_OFFSET   = 8'd0;
    localparam logic [7:0] CFG_BAR0_OFFSET = 8'd4;

endpackage

// ==== source/pci_addr_decode.sv ====
`timescale 1ns/1ps

module pci_addr_decode
    import pci_tgt_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 16
)
(
    input  logic        pci_clk_pad_i,
    input  logic        pci_rst_pad_i,
    input  logic        frame_i,
    input  logic        idsel_i,
    input  logic [31:0] ad_i,
    input  pci_cbe_u    cbe_i,
    input  logic [31:0] bar0_i,
    input  logic        busy_i,
    output pci_addr_s   addr_o
);

    localparam int unsigned AW = $clog2(MEM_WORDS);

    logic       frame_q;
    logic       start;
    logic       mem_cmd;
    logic       is_cfg;
    logic       is_write;
    logic       cfg_ok;
    logic       mem_ok;
    logic       claim;
    logic [7:0] cfg_word;
    logic       hit_q;
    logic       is_cfg_q;
    logic       is_write_q;
    logic [7:0] idx_q;

    // falling edge of frame# with the sequencer idle
    assign start = frame_q && !frame_i && !busy_i;

    always_comb
    begin
        mem_cmd  = 1'b0;
        is_cfg   = 1'b0;
        is_write = 1'b0;
        case (cbe_i.cmd)
            CMD_MEM_READ:
                mem_cmd = 1'b1;
            CMD_MEM_WRITE:
            begin
                mem_cmd  = 1'b1;
                is_write = 1'b1;
            end
            CMD_CFG_READ:
                is_cfg = 1'b1;
            CMD_CFG_WRITE:
            begin
                is_cfg   = 1'b1;
                is_write = 1'b1;
            end
            default:
                mem_cmd = 1'b0;
        endcase
    end

    // type 0 access to the implemented header words only
    assign cfg_word = ad_i[9:2];
    assign cfg_ok   = idsel_i && (ad_i[1:0] == 2'b00) &&
                      ((cfg_word - CFG_ID_OFFSET) <= (CFG_BAR0_OFFSET - CFG_ID_OFFSET));

    assign mem_ok = (ad_i[31:AW+2] == bar0_i[31:AW+2]);
    assign claim  = (mem_cmd && mem_ok) || (is_cfg && cfg_ok);

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            frame_q <= 1'b1;
            hit_q   <= 1'b0;
        end
        else
        begin
            frame_q <= frame_i;
            hit_q   <= start && claim;
        end
    end

    always_ff @(posedge pci_clk_pad_i)
    begin
        if (start)
        begin
            is_cfg_q   <= is_cfg;
            is_write_q <= is_write;
            idx_q      <= is_cfg ? cfg_word : 8'(ad_i[AW+1:2]);
        end
    end

    assign addr_o = '{hit: hit_q, is_cfg: is_cfg_q, is_write: is_write_q, idx: idx_q};

    a_mem_not_cfg: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        start && (cbe_i.cmd == CMD_MEM_READ || cbe_i.cmd == CMD_MEM_WRITE)
        |=> !(addr_o.hit && addr_o.is_cfg));

endmodule

// ==== source/pci_tgt_sequencer.sv ====
`timescale 1ns/1ps

module pci_tgt_sequencer
    import pci_tgt_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 16
)
(
    input  logic        pci_clk_pad_i,
    input  logic        pci_rst_pad_i,
    input  logic        frame_i,
    input  logic        irdy_i,
    input  logic [31:0] ad_i,
    input  pci_cbe_u    cbe_i,
    input  pci_addr_s   addr_i,
    input  logic [31:0] rd_data_i,
    output logic        devsel_o,
    output logic        trdy_o,
    output logic        stop_o,
    output logic        tgt_oe_o,
    output logic [31:0] ad_o,
    output logic        ad_oe_o,
    output logic        busy_o,
    output logic        wr_o,
    output logic        cfg_o,
    output logic [7:0]  idx_o,
    output logic [3:0]  be_o,
    output logic [31:0] wr_data_o,
    output pci_data_s   data_o
);

    localparam logic [7:0] LAST_IDX = 8'(MEM_WORDS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TURN,
        ST_DATA,
        ST_RELEASE
    } state_e;

    state_e     state_q;
    logic [7:0] idx_q;
    logic       is_write_q;
    logic       is_cfg_q;
    logic       stop_q;
    logic       xfer;

    // config accesses are single word, so their window ends at once
    function automatic logic last_word(input logic [7:0] idx, input logic cfg);
        return cfg || (idx == LAST_IDX);
    endfunction

    assign xfer = (state_q == ST_DATA) && !irdy_i;

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            state_q    <= ST_IDLE;
            idx_q      <= '0;
            is_write_q <= 1'b0;
            is_cfg_q   <= 1'b0;
            stop_q     <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (addr_i.hit)
                    begin
                        idx_q      <= addr_i.idx;
                        is_write_q <= addr_i.is_write;
                        is_cfg_q   <= addr_i.is_cfg;
                        if (addr_i.is_write)
                        begin
                            state_q <= ST_DATA;
                            stop_q  <= last_word(addr_i.idx, addr_i.is_cfg) && !frame_i;
                        end
                        else
                            state_q <= ST_TURN;
                    end
                end
                ST_TURN:
                begin
                    state_q <= ST_DATA;
                    stop_q  <= last_word(idx_q, is_cfg_q) && !frame_i;
                end
                ST_DATA:
                begin
                    // irdy# high holds index and data
                    if (xfer)
                    begin
                        idx_q <= idx_q + 8'd1;
                        if (frame_i || stop_q)
                        begin
                            state_q <= ST_RELEASE;
                            stop_q  <= 1'b0;
                        end
                        else
                            stop_q <= last_word(idx_q + 8'd1, is_cfg_q) && !frame_i;
                    end
                end
                default:
                    state_q <= ST_IDLE;
            endcase
        end
    end

    // release drives everything high for one cycle before letting go
    assign devsel_o = !((state_q == ST_TURN) || (state_q == ST_DATA));
    assign trdy_o   = !(state_q == ST_DATA);
    assign stop_o   = !stop_q;
    assign tgt_oe_o = (state_q != ST_IDLE);

    // no drive during the turnaround cycle
    assign ad_o    = rd_data_i;
    assign ad_oe_o = (state_q == ST_DATA) && !is_write_q;

    assign busy_o    = (state_q != ST_IDLE);
    assign wr_o      = xfer && is_write_q;
    assign cfg_o     = is_cfg_q;
    assign idx_o     = idx_q;
    assign be_o      = ~cbe_i.be_n;
    assign wr_data_o = ad_i;

    assign data_o = '{valid: xfer, is_write: is_write_q,
                      ad: is_write_q ? ad_i : rd_data_i, cbe: cbe_i.be_n};

    // a read keeps devsel# ahead of trdy# by the turnaround
    a_trdy_devsel: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        !trdy_o |-> !devsel_o && tgt_oe_o && (is_write_q || $past(!devsel_o)));

    a_ad_read_only: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        ad_oe_o |-> !is_write_q && $past(!devsel_o));

endmodule

// ==== source/pci_tgt_regfile.sv ====
`timescale 1ns/1ps

module pci_tgt_regfile
    import pci_tgt_pkg::*;
#(
    parameter logic [31:0] VENDOR_DEVICE_ID = 32'h1234_5678,
    parameter int unsigned MEM_WORDS        = 16
)
(
    input  logic        pci_clk_pad_i,
    input  logic        pci_rst_pad_i,
    input  logic        wr_i,
    input  logic        cfg_i,
    input  logic [7:0]  idx_i,
    input  logic [3:0]  be_i,
    input  logic [31:0] wr_data_i,
    output logic [31:0] rd_data_o,
    output logic [31:0] bar0_o
);

    localparam int unsigned AW       = $clog2(MEM_WORDS);
    localparam logic [31:0] WIN_MASK = 32'(MEM_WORDS * 4 - 1);

    logic [31:0]   mem_q [MEM_WORDS];
    logic [31:0]   bar0_q;
    logic [AW-1:0] word;

    function automatic logic [31:0] merge_be(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign word = idx_i[AW-1:0];

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            bar0_q <= '0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem_q[i] <= '0;
        end
        else if (wr_i)
        begin
            if (cfg_i)
            begin
                // size bits of the window are hardwired to zero
                if (idx_i == CFG_BAR0_OFFSET)
                    bar0_q <= merge_be(bar0_q, wr_data_i, be_i) & ~WIN_MASK;
            end
            else
                mem_q[word] <= merge_be(mem_q[word], wr_data_i, be_i);
        end
    end

    always_comb
    begin
        if (cfg_i)
        begin
            if (idx_i == CFG_ID_OFFSET)
                rd_data_o = VENDOR_DEVICE_ID;
            else if (idx_i == CFG_BAR0_OFFSET)
                rd_data_o = bar0_q;
            else
                rd_data_o = '0;
        end
        else
            rd_data_o = mem_q[word];
    end

    assign bar0_o = bar0_q;

endmodule

// ==== source/pci_parity_unit.sv ====
`timescale 1ns/1ps

module pci_parity_unit
    import pci_tgt_pkg::*;
(
    input  logic      pci_clk_pad_i,
    input  logic      pci_rst_pad_i,
    input  pci_data_s data_i,
    input  logic      par_i,
    output logic      par_o,
    output logic      par_oe_o,
    output logic      perr_o,
    output logic      perr_oe_o
);

    logic par_q;
    logic rd_q;
    logic wr_q;
    logic perr_q;
    logic perr_rel_q;

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            rd_q       <= 1'b0;
            wr_q       <= 1'b0;
            perr_q     <= 1'b0;
            perr_rel_q <= 1'b0;
        end
        else
        begin
            rd_q       <= data_i.valid && !data_i.is_write;
            wr_q       <= data_i.valid && data_i.is_write;
            // master par arrives one cycle after its write data
            perr_q     <= wr_q && (par_i != par_q);
            perr_rel_q <= perr_q;
        end
    end

    // even parity over ad and c/be#
    always_ff @(posedge pci_clk_pad_i)
    begin
        if (data_i.valid)
            par_q <= ^{data_i.ad, data_i.cbe};
    end

    assign par_o    = par_q;
    assign par_oe_o = rd_q;

    // perr# low for one cycle, then high for one before release
    assign perr_o    = !perr_q;
    assign perr_oe_o = perr_q || perr_rel_q;

    a_par_after_read: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        par_oe_o |-> $past(data_i.valid && !data_i.is_write) && !perr_oe_o);

endmodule

// ==== source/pci_target_top.sv ====
`timescale 1ns/1ps

module pci_target_top
    import pci_tgt_pkg::*;
#(
    parameter logic [31:0] VENDOR_DEVICE_ID = 32'h1234_5678,
    parameter int unsigned MEM_WORDS        = 16
)
(
    input  logic        pci_clk_pad_i,
    input  logic        pci_rst_pad_i,
    input  logic        pci_frame_i,
    input  logic        pci_irdy_i,
    input  logic        pci_idsel_i,
    input  logic [31:0] pci_ad_i,
    input  logic [3:0]  pci_cbe_i,
    input  logic        pci_par_i,
    output logic [31:0] pci_ad_o,
    output logic        pci_ad_oe_o,
    output logic        pci_devsel_o,
    output logic        pci_trdy_o,
    output logic        pci_stop_o,
    output logic        pci_tgt_oe_o,
    output logic        pci_par_o,
    output logic        pci_par_oe_o,
    output logic        pci_perr_o,
    output logic        pci_perr_oe_o
);

    pci_addr_s   addr;
    pci_data_s   data;
    logic        busy;
    logic        wr;
    logic        cfg;
    logic [7:0]  idx;
    logic [3:0]  be;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    logic [31:0] bar0;

    pci_addr_decode #(
        .MEM_WORDS (MEM_WORDS)
    ) i_pci_addr_decode (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .frame_i       (pci_frame_i),
        .idsel_i       (pci_idsel_i),
        .ad_i          (pci_ad_i),
        .cbe_i         (pci_cbe_i),
        .bar0_i        (bar0),
        .busy_i        (busy),
        .addr_o        (addr)
    );

    pci_tgt_sequencer #(
        .MEM_WORDS (MEM_WORDS)
    ) i_pci_tgt_sequencer (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .frame_i       (pci_frame_i),
        .irdy_i        (pci_irdy_i),
        .ad_i          (pci_ad_i),
        .cbe_i         (pci_cbe_i),
        .addr_i        (addr),
        .rd_data_i     (rd_data),
        .devsel_o      (pci_devsel_o),
        .trdy_o        (pci_trdy_o),
        .stop_o        (pci_stop_o),
        .tgt_oe_o      (pci_tgt_oe_o),
        .ad_o          (pci_ad_o),
        .ad_oe_o       (pci_ad_oe_o),
        .busy_o        (busy),
        .wr_o          (wr),
        .cfg_o         (cfg),
        .idx_o         (idx),
        .be_o          (be),
        .wr_data_o     (wr_data),
        .data_o        (data)
    );

    pci_tgt_regfile #(
        .VENDOR_DEVICE_ID (VENDOR_DEVICE_ID),
        .MEM_WORDS        (MEM_WORDS)
    ) i_pci_tgt_regfile (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .wr_i          (wr),
        .cfg_i         (cfg),
        .idx_i         (idx),
        .be_i          (be),
        .wr_data_i     (wr_data),
        .rd_data_o     (rd_data),
        .bar0_o        (bar0)
    );

    pci_parity_unit i_pci_parity_unit (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .data_i        (data),
        .par_i         (pci_par_i),
        .par_o         (pci_par_o),
        .par_oe_o      (pci_par_oe_o),
        .perr_o        (pci_perr_o),
        .perr_oe_o     (pci_perr_oe_o)
    );

endmodule

// ==== dv/tb_pci_target.sv ====
`timescale 1ns/1ps

module tb_pci_target
    import pci_tgt_pkg::*;
();

    localparam logic [31:0] VID       = 32'h1af4_1040;
    localparam int unsigned MEM_WORDS = 16;
    localparam int unsigned AW        = $clog2(MEM_WORDS);
    localparam logic [7:0]  LAST      = 8'(MEM_WORDS - 1);
    localparam logic [31:0] WIN_MASK  = 32'(MEM_WORDS * 4 - 1);
    localparam logic [31:0] BAR       = 32'h8000_0000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        frame;
    logic        irdy;
    logic        idsel;
    logic [31:0] ad;
    logic [3:0]  cbe;
    logic        par_in;
    logic [31:0] pci_ad_o;
    logic        pci_ad_oe_o;
    logic        pci_devsel_o;
    logic        pci_trdy_o;
    logic        pci_stop_o;
    logic        pci_tgt_oe_o;
    logic        pci_par_o;
    logic        pci_par_oe_o;
    logic        pci_perr_o;
    logic        pci_perr_oe_o;

    // pads as the bus sees them, pulled up when released
    logic devsel_n;
    logic trdy_n;
    logic stop_n;
    logic perr_n;
    logic xfer;

    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] bar0_shadow;
    logic [31:0] exp_data;
    logic [31:0] seed;
    logic [7:0]  cur_idx;
    logic        rd_par_exp;
    bit          addr_ph;
    bit          rd_cyc;
    bit          wr_cyc;
    bit          cfg_cyc;
    bit          par_bad;
    bit          idle_chk;
    bit          miss_chk;
    string       cur_test;
    int          errors;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;

    always #20 clk = ~clk;

    assign devsel_n = pci_tgt_oe_o ? pci_devsel_o : 1'b1;
    assign trdy_n   = pci_tgt_oe_o ? pci_trdy_o : 1'b1;
    assign stop_n   = pci_tgt_oe_o ? pci_stop_o : 1'b1;
    assign perr_n   = pci_perr_oe_o ? pci_perr_o : 1'b1;
    assign xfer     = !trdy_n && !irdy;

    pci_target_top #(
        .VENDOR_DEVICE_ID (VID),
        .MEM_WORDS        (MEM_WORDS)
    ) i_pci_target_top (
        .pci_clk_pad_i (clk),
        .pci_rst_pad_i (rst_n),
        .pci_frame_i   (frame),
        .pci_irdy_i    (irdy),
        .pci_idsel_i   (idsel),
        .pci_ad_i      (ad),
        .pci_cbe_i     (cbe),
        .pci_par_i     (par_in),
        .pci_ad_o      (pci_ad_o),
        .pci_ad_oe_o   (pci_ad_oe_o),
        .pci_devsel_o  (pci_devsel_o),
        .pci_trdy_o    (pci_trdy_o),
        .pci_stop_o    (pci_stop_o),
        .pci_tgt_oe_o  (pci_tgt_oe_o),
        .pci_par_o     (pci_par_o),
        .pci_par_oe_o  (pci_par_oe_o),
        .pci_perr_o    (pci_perr_o),
        .pci_perr_oe_o (pci_perr_oe_o)
    );

    // parity the target owes for the phase just read
    always @(posedge clk)
        rd_par_exp <= ^{exp_data, cbe};

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  en);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (en[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function logic [31:0] expected_word(input logic [7:0] idx, input bit cfg);
        if (!cfg)
            return shadow[idx[AW-1:0]];
        if (idx == 8'd0)
            return VID;
        if (idx == 8'd4)
            return bar0_shadow;
        return '0;
    endfunction

    task report_fail(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    endtask

    a_idle_oe: assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> !(pci_ad_oe_o || pci_tgt_oe_o || pci_par_oe_o || pci_perr_oe_o))
        else report_fail("idle enables", 32'h0, 32'({$sampled(pci_ad_oe_o),
            $sampled(pci_tgt_oe_o), $sampled(pci_par_oe_o), $sampled(pci_perr_oe_o)}));

    // devsel# from the edge after the claim, trdy# then only on a write
    a_claim: assert property (@(posedge clk) disable iff (!rst_n)
        addr_ph |-> ##2 !devsel_n && (trdy_n == !wr_cyc))
        else report_fail("claim timing", 32'({1'b0, !$sampled(wr_cyc)}),
            32'({$sampled(devsel_n), $sampled(trdy_n)}));

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cyc && xfer |-> pci_ad_oe_o && pci_ad_o == exp_data)
        else report_fail("read data", exp_data, $sampled(pci_ad_o));

    a_read_par: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cyc && xfer |=> pci_par_oe_o && pci_par_o == rd_par_exp)
        else report_fail("read parity", 32'($sampled(rd_par_exp)), 32'($sampled(pci_par_o)));

    a_perr_bad: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cyc && xfer && par_bad |-> ##2 perr_n == 1'b0)
        else report_fail("perr on bad parity", 32'h0, 32'($sampled(perr_n)));

    a_perr_good: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cyc && xfer && !par_bad |-> ##2 perr_n == 1'b1)
        else report_fail("perr on good parity", 32'h1, 32'($sampled(perr_n)));

    a_stop_last: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_cyc && xfer && cur_idx == LAST && !frame |-> !stop_n)
        else report_fail("stop at last word", 32'h0, 32'($sampled(stop_n)));

    a_miss: assert property (@(posedge clk) disable iff (!rst_n)
        miss_chk |-> !pci_tgt_oe_o && !pci_ad_oe_o)
        else report_fail("unclaimed cycle", 32'h0, 32'($sampled(pci_tgt_oe_o)));

    task idle_gap();
        repeat (4) @(posedge clk);
        #2;
        idle_chk = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        idle_chk = 1'b0;
    endtask

    task store_write(input logic [7:0] idx, input bit cfg, input logic [31:0] wd,
                     input logic [3:0] en);
        if (!cfg)
            shadow[idx[AW-1:0]] = merge_bytes(shadow[idx[AW-1:0]], wd, en);
        else if (idx == 8'd4)
            bar0_shadow = merge_bytes(bar0_shadow, wd, en) & ~WIN_MASK;
    endtask

    // one master cycle, n data phases unless the target disconnects
    task automatic bus_cycle(input logic [3:0] cmd, input logic [31:0] addr, input logic sel,
                             input int n, input bit stall, input logic [31:0] base_data,
                             input bit rand_wr, output int done);
        logic [31:0] r;
        logic [31:0] rb;
        logic [31:0] wd;
        logic [3:0]  be_n;
        logic [7:0]  idx;
        int          t;
        bit          fin;
        bit          stopped;
        idx  = cmd[3] ? addr[9:2] : 8'(addr[AW+1:2]);
        done = 0;
        fin  = 0;
        @(posedge clk);
        #2;
        frame   = 1'b0;
        ad      = addr;
        cbe     = cmd;
        idsel   = sel;
        addr_ph = 1'b1;
        @(posedge clk);
        #2;
        addr_ph = 1'b0;
        idsel   = 1'b0;
        wr_cyc  = cmd[0];
        rd_cyc  = !cmd[0];
        cfg_cyc = cmd[3];
        while (!fin)
        begin
            r    = next_rand();
            rb   = next_rand();
            wd   = rand_wr ? r : base_data + 32'(done);
            be_n = (rand_wr && cmd[0]) ? rb[7:4] : 4'b0000;
            if (stall && rb[20])
            begin
                irdy = 1'b1;
                @(posedge clk);
                #2;
            end
            frame    = (done == n - 1);
            irdy     = 1'b0;
            cbe      = be_n;
            ad       = cmd[0] ? wd : '0;
            cur_idx  = idx;
            exp_data = expected_word(idx, cmd[3]);
            t = 0;
            @(posedge clk);
            while (trdy_n !== 1'b0 && t < 16)
            begin
                t++;
                @(posedge clk);
            end
            if (t >= 16)
            begin
                $display("%s: target never asserted TRDY# within 16 cycles", cur_test);
                errors++;
                fin = 1;
                #2;
            end
            else
            begin
                stopped = (stop_n === 1'b0);
                if (cmd[0])
                    store_write(idx, cmd[3], wd, ~be_n);
                #2;
                // master par for the write phase that just completed
                par_in = (^{wd, be_n}) ^ par_bad;
                done++;
                idx++;
                fin = (done == n) || stopped;
            end
        end
        frame  = 1'b1;
        irdy   = 1'b1;
        ad     = '0;
        cbe    = '0;
        wr_cyc = 1'b0;
        rd_cyc = 1'b0;
        idle_gap();
    endtask

    task miss_probe(input logic [3:0] cmd, input logic [31:0] addr, input logic sel);
        @(posedge clk);
        #2;
        frame = 1'b0;
        ad    = addr;
        cbe   = cmd;
        idsel = sel;
        @(posedge clk);
        #2;
        frame    = 1'b1;
        irdy     = 1'b0;
        idsel    = 1'b0;
        cbe      = '0;
        ad       = '0;
        miss_chk = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        irdy     = 1'b1;
        miss_chk = 1'b0;
        idle_gap();
    endtask

    task begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task end_test();
        if (errors == err_mark)
        begin
            pass_cnt++;
            $display("%s: ok", cur_test);
        end
        else
        begin
            fail_cnt++;
            $display("%s: %0d errors", cur_test, errors - err_mark);
        end
    endtask

    task check_count(input string what, input int exp, input int act);
        if (exp != act)
            report_fail(what, 32'(exp), 32'(act));
    endtask

    initial
    begin
        int n;
        rst_n    = 1'b0;
        frame    = 1'b1;
        irdy     = 1'b1;
        idsel    = 1'b0;
        ad       = '0;
        cbe      = '0;
        par_in   = 1'b0;
        seed     = 32'ha094;
        errors   = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        bar0_shadow = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        begin_test("reset");
        idle_gap();
        end_test();

        begin_test("config");
        bus_cycle(CMD_CFG_READ, 32'h0, 1'b1, 1, 0, 32'h0, 0, n);
        bus_cycle(CMD_CFG_WRITE, 32'h10, 1'b1, 1, 0, 32'hffff_ffff, 0, n);
        bus_cycle(CMD_CFG_READ, 32'h10, 1'b1, 1, 0, 32'h0, 0, n);
        bus_cycle(CMD_CFG_WRITE, 32'h10, 1'b1, 1, 0, BAR, 0, n);
        bus_cycle(CMD_CFG_READ, 32'h10, 1'b1, 1, 0, 32'h0, 0, n);
        miss_probe(CMD_CFG_READ, 32'h0, 1'b0);
        end_test();

        begin_test("single");
        bus_cycle(CMD_MEM_WRITE, BAR + 32'd12, 1'b0, 1, 0, 32'h1122_3344, 0, n);
        bus_cycle(CMD_MEM_WRITE, BAR + 32'd12, 1'b0, 1, 0, 32'h0, 1, n);
        bus_cycle(CMD_MEM_READ, BAR + 32'd12, 1'b0, 1, 0, 32'h0, 0, n);
        end_test();

        begin_test("burst");
        bus_cycle(CMD_MEM_WRITE, BAR + 32'd8, 1'b0, 4, 1, 32'h0, 1, n);
        check_count("burst write length", 4, n);
        bus_cycle(CMD_MEM_READ, BAR + 32'd8, 1'b0, 4, 1, 32'h0, 0, n);
        check_count("burst read length", 4, n);
        // six words from three below the top, disconnect after four
        bus_cycle(CMD_MEM_WRITE, BAR + 32'(LAST - 3) * 4, 1'b0, 6, 1, 32'h0, 1, n);
        check_count("disconnect write length", 4, n);
        bus_cycle(CMD_MEM_READ, BAR + 32'(LAST - 3) * 4, 1'b0, 6, 1, 32'h0, 0, n);
        check_count("disconnect read length", 4, n);
        end_test();

        begin_test("parity");
        par_bad = 1'b1;
        bus_cycle(CMD_MEM_WRITE, BAR + 32'd20, 1'b0, 1, 0, 32'h0, 1, n);
        par_bad = 1'b0;
        bus_cycle(CMD_MEM_WRITE, BAR + 32'd24, 1'b0, 2, 0, 32'h0, 1, n);
        bus_cycle(CMD_MEM_READ, BAR + 32'd20, 1'b0, 3, 1, 32'h0, 0, n);
        end_test();

        begin_test("miss");
        miss_probe(CMD_MEM_READ, 32'h0000_1000, 1'b0);
        miss_probe(CMD_MEM_WRITE, BAR + 32'h100, 1'b0);
        end_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
source/pci_tgt_pkg.sv
source/pci_addr_decode.sv
source/pci_tgt_sequencer.sv
source/pci_tgt_regfile.sv
source/pci_parity_unit.sv
source/pci_target_top.sv
dv/tb_pci_target.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pci_target
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
